//--- cache_cfg_pkg.sv
package cache_cfg_pkg;

  //////////////////////////////////////////////////
  // Geometry

  localparam int num_ways   = 4;
  localparam int line_words = 16;

  //////////////////////////////////////////////////
  // Address fields and data

  typedef logic [31:0] addr_t;    // Byte address
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;      // One bit per byte lane

  typedef logic [21:0] tag_t;     // addr[31:10]
  typedef logic [3:0]  index_t;   // addr[9:6]
  typedef logic [3:0]  offset_t;  // addr[5:2], word in line

  typedef logic [1:0]  way_t;
  typedef logic [1:0]  age_t;     // 0 is most recently used

endpackage

//--- cache_ctrl_pkg.sv
package cache_ctrl_pkg;

  // Lookup controller
  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_hit,
    ctrl_miss,
    ctrl_retry
  } ctrl_state_e;

  // Burst sequencer
  typedef enum logic [1:0] {
    fill_idle,
    fill_writeback,
    fill_refill,
    fill_install
  } fill_state_e;

  // Data array owners
  typedef enum logic {
    owner_ctrl,
    owner_fill
  } owner_e;

endpackage

//--- cache_data_array.sv
module cache_data_array
(
  input  logic                   clk,
  input  cache_cfg_pkg::index_t  index,
  input  cache_cfg_pkg::way_t    way,
  input  cache_cfg_pkg::offset_t offset,
  input  logic                   we,
  input  cache_cfg_pkg::be_t     be,
  input  cache_cfg_pkg::word_t   wdata,
  output cache_cfg_pkg::word_t   rd_data
);

  localparam int num_sets = 2 ** $bits(cache_cfg_pkg::index_t);
  localparam int depth    = cache_cfg_pkg::num_ways * num_sets * cache_cfg_pkg::line_words;
  localparam int aw       = $clog2(depth);

  cache_cfg_pkg::word_t mem [depth];
  logic [aw-1:0]        addr;

  // Way major, then set, then word
  assign addr = {way, index, offset};

  always_ff @(posedge clk)
  begin
    if (we)
      for (int b = 0; b < $bits(cache_cfg_pkg::be_t); b++)
        if (be[b])
          mem[addr][8*b +: 8] <= wdata[8*b +: 8];
  end

  assign rd_data = mem[addr];  // Async read

endmodule

//--- data_array_arbiter.sv
module data_array_arbiter
(
  input  logic                   ctrl_req,
  input  logic                   ctrl_we,
  input  cache_cfg_pkg::way_t    ctrl_way,
  input  cache_cfg_pkg::offset_t ctrl_offset,
  input  cache_cfg_pkg::word_t   ctrl_wdata,
  input  cache_cfg_pkg::be_t     ctrl_be,
  output cache_cfg_pkg::word_t   ctrl_rd_data,
  input  logic                   fill_req,
  input  logic                   fill_we,
  input  cache_cfg_pkg::way_t    fill_way,
  input  cache_cfg_pkg::offset_t fill_offset,
  input  cache_cfg_pkg::word_t   fill_wdata,
  output cache_cfg_pkg::word_t   fill_rd_data,
  output logic                   arr_we,
  output cache_cfg_pkg::way_t    arr_way,
  output cache_cfg_pkg::offset_t arr_offset,
  output cache_cfg_pkg::word_t   arr_wdata,
  output cache_cfg_pkg::be_t     arr_be,
  input  cache_cfg_pkg::word_t   rd_data
);

  cache_ctrl_pkg::owner_e grant;

  // Fill engine has fixed priority
  assign grant = fill_req ? cache_ctrl_pkg::owner_fill : cache_ctrl_pkg::owner_ctrl;

  always_comb
  begin
    if (grant == cache_ctrl_pkg::owner_fill)
    begin
      arr_we     = fill_we;
      arr_way    = fill_way;
      arr_offset = fill_offset;
      arr_wdata  = fill_wdata;
      arr_be     = '1;  // Whole words from the bus
    end
    else
    begin
      arr_we     = ctrl_req && ctrl_we;
      arr_way    = ctrl_way;
      arr_offset = ctrl_offset;
      arr_wdata  = ctrl_wdata;
      arr_be     = ctrl_be;
    end
  end

  assign ctrl_rd_data = (grant == cache_ctrl_pkg::owner_ctrl) ? rd_data : '0;
  assign fill_rd_data = (grant == cache_ctrl_pkg::owner_fill) ? rd_data : '0;

endmodule

//--- cache_tag_store.sv
module cache_tag_store
(
  input  logic                  clk,
  input  logic                  rst,
  input  cache_cfg_pkg::index_t index,
  input  cache_cfg_pkg::tag_t   tag,
  output logic                  hit,
  output cache_cfg_pkg::way_t   hit_way,
  output cache_cfg_pkg::way_t   victim_way,
  output logic                  victim_dirty,
  output cache_cfg_pkg::tag_t   victim_tag,
  input  logic                  touch,
  input  logic                  mark_dirty,
  input  cache_cfg_pkg::way_t   access_way,
  input  logic                  install,
  input  cache_cfg_pkg::way_t   install_way,
  input  cache_cfg_pkg::tag_t   install_tag,
  input  cache_cfg_pkg::index_t install_index
);

  localparam int num_sets = 2 ** $bits(cache_cfg_pkg::index_t);

  cache_cfg_pkg::tag_t   tags  [num_sets][cache_cfg_pkg::num_ways];
  logic                  valid [num_sets][cache_cfg_pkg::num_ways];
  logic                  dirty [num_sets][cache_cfg_pkg::num_ways];
  cache_cfg_pkg::age_t   age   [num_sets][cache_cfg_pkg::num_ways];

  logic                  found_invalid;
  logic                  upd;
  cache_cfg_pkg::way_t   upd_way;
  cache_cfg_pkg::index_t upd_index;

  //////////////////////////////////////////////////
  // Lookup and victim choice

  always_comb
  begin
    hit           = 1'b0;
    hit_way       = '0;
    found_invalid = 1'b0;
    victim_way    = '0;
    for (int w = 0; w < cache_cfg_pkg::num_ways; w++)
    begin
      if (valid[index][w] && (tags[index][w] == tag))
      begin
        hit     = 1'b1;
        hit_way = cache_cfg_pkg::way_t'(w);
      end
      if (!valid[index][w] && !found_invalid)
      begin
        found_invalid = 1'b1;
        victim_way    = cache_cfg_pkg::way_t'(w);  // Lowest empty way
      end
    end
    // Set full, oldest goes, low way wins a tie
    if (!found_invalid)
      for (int w = 1; w < cache_cfg_pkg::num_ways; w++)
        if (age[index][w] > age[index][victim_way])
          victim_way = cache_cfg_pkg::way_t'(w);
  end

  assign victim_dirty = dirty[index][victim_way];
  assign victim_tag   = tags[index][victim_way];

  //////////////////////////////////////////////////
  // Updates

  // Install counts as a use of the new line
  assign upd       = touch || install;
  assign upd_way   = install ? install_way : access_way;
  assign upd_index = install ? install_index : index;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < num_sets; s++)
        for (int w = 0; w < cache_cfg_pkg::num_ways; w++)
        begin
          valid[s][w] <= 1'b0;
          dirty[s][w] <= 1'b0;
          age[s][w]   <= cache_cfg_pkg::age_t'(w);
        end
    end
    else
    begin
      if (install)
      begin
        valid[install_index][install_way] <= 1'b1;
        dirty[install_index][install_way] <= 1'b0;
      end
      if (mark_dirty)
        dirty[index][access_way] <= 1'b1;
      if (upd)
        for (int w = 0; w < cache_cfg_pkg::num_ways; w++)
          if (cache_cfg_pkg::way_t'(w) == upd_way)
            age[upd_index][w] <= '0;
          else if ((age[upd_index][w] <= age[upd_index][upd_way]) &&
                   (age[upd_index][w] != '1))
            age[upd_index][w] <= age[upd_index][w] + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (install)
      tags[install_index][install_way] <= install_tag;
  end

endmodule

//--- line_fill_engine.sv
module line_fill_engine
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fill_start,
  input  cache_cfg_pkg::tag_t    fill_tag,
  input  cache_cfg_pkg::index_t  fill_index,
  input  cache_cfg_pkg::tag_t    old_tag,
  input  cache_cfg_pkg::way_t    old_way,
  input  logic                   old_dirty,
  output logic                   fill_done,
  output logic                   sen,
  output logic                   wen,
  output cache_cfg_pkg::addr_t   bus_addr,
  output cache_cfg_pkg::word_t   bus_wdata,
  input  cache_cfg_pkg::word_t   bus_rdata,
  input  logic                   data_ok,
  output logic                   fill_req,
  output logic                   fill_we,
  output cache_cfg_pkg::way_t    fill_way,
  output cache_cfg_pkg::offset_t fill_offset,
  output cache_cfg_pkg::word_t   fill_wdata,
  input  cache_cfg_pkg::word_t   rd_data,
  output logic                   install,
  output cache_cfg_pkg::way_t    install_way,
  output cache_cfg_pkg::tag_t    install_tag,
  output cache_cfg_pkg::index_t  install_index
);

  cache_ctrl_pkg::fill_state_e state;
  cache_cfg_pkg::offset_t      cnt;   // Word in burst
  logic                        last_word;

  assign last_word = data_ok && (cnt == cache_cfg_pkg::offset_t'(cache_cfg_pkg::line_words - 1));

  // Miss info from the controller stays put until fill_done
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= cache_ctrl_pkg::fill_idle;
      cnt   <= '0;
      sen   <= 1'b0;
      wen   <= 1'b0;
    end
    else
    begin
      case (state)
        cache_ctrl_pkg::fill_idle:
          if (fill_start)
          begin
            state <= old_dirty ? cache_ctrl_pkg::fill_writeback : cache_ctrl_pkg::fill_refill;
            cnt   <= '0;
            sen   <= 1'b1;
            wen   <= old_dirty;
          end
        cache_ctrl_pkg::fill_writeback:
          if (data_ok)
          begin
            cnt <= cnt + 1'b1;
            if (last_word)
            begin
              state <= cache_ctrl_pkg::fill_refill;
              sen   <= 1'b0;  // One idle cycle on the bus
              wen   <= 1'b0;
            end
          end
        cache_ctrl_pkg::fill_refill:
          if (!sen)
            sen <= 1'b1;
          else if (data_ok)
          begin
            cnt <= cnt + 1'b1;
            if (last_word)
            begin
              state <= cache_ctrl_pkg::fill_install;
              sen   <= 1'b0;
            end
          end
        default:
          state <= cache_ctrl_pkg::fill_idle;
      endcase
    end
  end

  // Line base, victim's during write-back
  assign bus_addr  = {wen ? old_tag : fill_tag, fill_index, 6'b0};
  assign bus_wdata = rd_data;

  assign fill_req    = (state == cache_ctrl_pkg::fill_writeback) ||
                       (state == cache_ctrl_pkg::fill_refill);
  assign fill_we     = (state == cache_ctrl_pkg::fill_refill) && sen && data_ok;
  assign fill_way    = old_way;
  assign fill_offset = cnt;
  assign fill_wdata  = bus_rdata;

  assign install       = (state == cache_ctrl_pkg::fill_install);
  assign install_way   = old_way;
  assign install_tag   = fill_tag;
  assign install_index = fill_index;
  assign fill_done     = install;

endmodule

//--- cache_ctrl.sv
module cache_ctrl
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req,
  input  logic                   wreq,
  input  cache_cfg_pkg::addr_t   cpu_addr,
  input  cache_cfg_pkg::word_t   cpu_wdata,
  input  cache_cfg_pkg::be_t     cpu_be,
  output cache_cfg_pkg::word_t   cpu_rdata,
  output logic                   ok,
  output logic                   miss,
  input  logic                   hit,
  input  cache_cfg_pkg::way_t    hit_way,
  input  cache_cfg_pkg::way_t    victim_way,
  input  logic                   victim_dirty,
  input  cache_cfg_pkg::tag_t    victim_tag,
  output logic                   touch,
  output logic                   mark_dirty,
  output logic                   fill_start,
  output cache_cfg_pkg::tag_t    fill_tag,
  output cache_cfg_pkg::index_t  fill_index,
  output cache_cfg_pkg::tag_t    old_tag,
  output cache_cfg_pkg::way_t    old_way,
  output logic                   old_dirty,
  input  logic                   fill_done,
  output logic                   ctrl_req,
  output logic                   ctrl_we,
  output cache_cfg_pkg::way_t    ctrl_way,
  output cache_cfg_pkg::offset_t ctrl_offset,
  output cache_cfg_pkg::word_t   ctrl_wdata,
  output cache_cfg_pkg::be_t     ctrl_be,
  input  cache_cfg_pkg::word_t   rd_data
);

  cache_ctrl_pkg::ctrl_state_e state;
  cache_ctrl_pkg::ctrl_state_e state_next;
  logic                        lookup_miss;
  logic                        access;

  assign lookup_miss = (state == cache_ctrl_pkg::ctrl_idle) && req && !hit;

  // Retry only completes if the installed line is really there
  assign access = (state == cache_ctrl_pkg::ctrl_hit) ||
                  ((state == cache_ctrl_pkg::ctrl_retry) && hit);

  always_comb
  begin
    state_next = state;
    case (state)
      cache_ctrl_pkg::ctrl_idle:
        if (req)
          state_next = hit ? cache_ctrl_pkg::ctrl_hit : cache_ctrl_pkg::ctrl_miss;
      cache_ctrl_pkg::ctrl_miss:
        if (fill_done)
          state_next = cache_ctrl_pkg::ctrl_retry;
      default:
        state_next = cache_ctrl_pkg::ctrl_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= cache_ctrl_pkg::ctrl_idle;
      fill_start <= 1'b0;
    end
    else
    begin
      state      <= state_next;
      fill_start <= lookup_miss;  // First cycle of ctrl_miss
    end
  end

  // Miss line and victim, held until the next miss
  always_ff @(posedge clk)
  begin
    if (lookup_miss)
    begin
      fill_tag   <= cpu_addr[31:10];
      fill_index <= cpu_addr[9:6];
      old_tag    <= victim_tag;
      old_way    <= victim_way;
      old_dirty  <= victim_dirty;
    end
  end

  assign ok         = access;
  assign miss       = lookup_miss || (state == cache_ctrl_pkg::ctrl_miss);
  assign touch      = access;
  assign mark_dirty = access && wreq;
  assign cpu_rdata  = rd_data;

  // Array port for hits
  assign ctrl_req    = access;
  assign ctrl_we     = access && wreq;
  assign ctrl_way    = hit_way;
  assign ctrl_offset = cpu_addr[5:2];
  assign ctrl_wdata  = cpu_wdata;
  assign ctrl_be     = cpu_be;

endmodule

//--- dcache_top.sv
module dcache_top
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  logic                 wreq,
  input  cache_cfg_pkg::addr_t cpu_addr,
  input  cache_cfg_pkg::word_t cpu_wdata,
  input  cache_cfg_pkg::be_t   cpu_be,
  output cache_cfg_pkg::word_t cpu_rdata,
  output logic                 ok,
  output logic                 miss,
  output logic                 sen,
  output logic                 wen,
  output cache_cfg_pkg::addr_t bus_addr,
  output cache_cfg_pkg::word_t bus_wdata,
  input  cache_cfg_pkg::word_t bus_rdata,
  input  logic                 data_ok
);

  // Lookup results
  logic                    hit;
  cache_cfg_pkg::way_t     hit_way;
  cache_cfg_pkg::way_t     victim_way;
  logic                    victim_dirty;
  cache_cfg_pkg::tag_t     victim_tag;
  logic                    touch;
  logic                    mark_dirty;

  // Miss handoff
  logic                    fill_start;
  logic                    fill_done;
  cache_cfg_pkg::tag_t     fill_tag;
  cache_cfg_pkg::index_t   fill_index;
  cache_cfg_pkg::tag_t     old_tag;
  cache_cfg_pkg::way_t     old_way;
  logic                    old_dirty;
  logic                    install;
  cache_cfg_pkg::way_t     install_way;
  cache_cfg_pkg::tag_t     install_tag;
  cache_cfg_pkg::index_t   install_index;

  // Array requests
  logic                    ctrl_req;
  logic                    ctrl_we;
  cache_cfg_pkg::way_t     ctrl_way;
  cache_cfg_pkg::offset_t  ctrl_offset;
  cache_cfg_pkg::word_t    ctrl_wdata;
  cache_cfg_pkg::be_t      ctrl_be;
  cache_cfg_pkg::word_t    ctrl_rdata;
  logic                    fill_req;
  logic                    fill_we;
  cache_cfg_pkg::way_t     fill_way;
  cache_cfg_pkg::offset_t  fill_offset;
  cache_cfg_pkg::word_t    fill_wdata;
  cache_cfg_pkg::word_t    fill_rdata;

  // Single array port
  logic                    arr_we;
  cache_cfg_pkg::way_t     arr_way;
  cache_cfg_pkg::offset_t  arr_offset;
  cache_cfg_pkg::word_t    arr_wdata;
  cache_cfg_pkg::be_t      arr_be;
  cache_cfg_pkg::word_t    arr_rdata;

  cache_ctrl ctrl_i
  (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .wreq         (wreq),
    .cpu_addr     (cpu_addr),
    .cpu_wdata    (cpu_wdata),
    .cpu_be       (cpu_be),
    .cpu_rdata    (cpu_rdata),
    .ok           (ok),
    .miss         (miss),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .touch        (touch),
    .mark_dirty   (mark_dirty),
    .fill_start   (fill_start),
    .fill_tag     (fill_tag),
    .fill_index   (fill_index),
    .old_tag      (old_tag),
    .old_way      (old_way),
    .old_dirty    (old_dirty),
    .fill_done    (fill_done),
    .ctrl_req     (ctrl_req),
    .ctrl_we      (ctrl_we),
    .ctrl_way     (ctrl_way),
    .ctrl_offset  (ctrl_offset),
    .ctrl_wdata   (ctrl_wdata),
    .ctrl_be      (ctrl_be),
    .rd_data      (ctrl_rdata)
  );

  // Lookup always uses the held CPU address
  cache_tag_store tags_i
  (
    .clk           (clk),
    .rst           (rst),
    .index         (cpu_addr[9:6]),
    .tag           (cpu_addr[31:10]),
    .hit           (hit),
    .hit_way       (hit_way),
    .victim_way    (victim_way),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag),
    .touch         (touch),
    .mark_dirty    (mark_dirty),
    .access_way    (ctrl_way),
    .install       (install),
    .install_way   (install_way),
    .install_tag   (install_tag),
    .install_index (install_index)
  );

  line_fill_engine fill_i
  (
    .clk           (clk),
    .rst           (rst),
    .fill_start    (fill_start),
    .fill_tag      (fill_tag),
    .fill_index    (fill_index),
    .old_tag       (old_tag),
    .old_way       (old_way),
    .old_dirty     (old_dirty),
    .fill_done     (fill_done),
    .sen           (sen),
    .wen           (wen),
    .bus_addr      (bus_addr),
    .bus_wdata     (bus_wdata),
    .bus_rdata     (bus_rdata),
    .data_ok       (data_ok),
    .fill_req      (fill_req),
    .fill_we       (fill_we),
    .fill_way      (fill_way),
    .fill_offset   (fill_offset),
    .fill_wdata    (fill_wdata),
    .rd_data       (fill_rdata),
    .install       (install),
    .install_way   (install_way),
    .install_tag   (install_tag),
    .install_index (install_index)
  );

  data_array_arbiter arb_i
  (
    .ctrl_req     (ctrl_req),
    .ctrl_we      (ctrl_we),
    .ctrl_way     (ctrl_way),
    .ctrl_offset  (ctrl_offset),
    .ctrl_wdata   (ctrl_wdata),
    .ctrl_be      (ctrl_be),
    .ctrl_rd_data (ctrl_rdata),
    .fill_req     (fill_req),
    .fill_we      (fill_we),
    .fill_way     (fill_way),
    .fill_offset  (fill_offset),
    .fill_wdata   (fill_wdata),
    .fill_rd_data (fill_rdata),
    .arr_we       (arr_we),
    .arr_way      (arr_way),
    .arr_offset   (arr_offset),
    .arr_wdata    (arr_wdata),
    .arr_be       (arr_be),
    .rd_data      (arr_rdata)
  );

  cache_data_array data_i
  (
    .clk     (clk),
    .index   (cpu_addr[9:6]),
    .way     (arr_way),
    .offset  (arr_offset),
    .we      (arr_we),
    .be      (arr_be),
    .wdata   (arr_wdata),
    .rd_data (arr_rdata)
  );

endmodule

//--- tb_bus_memory.sv
module tb_bus_memory
(
  input  logic                 clk,
  input  logic                 sen,
  input  logic                 wen,
  input  cache_cfg_pkg::addr_t bus_addr,
  input  cache_cfg_pkg::word_t bus_wdata,
  output cache_cfg_pkg::word_t bus_rdata,
  output logic                 data_ok
);

  localparam int mem_words = 4096;  // 16 KB, addr[13:2]
  localparam int seed      = 4293;

  cache_cfg_pkg::word_t mem [mem_words];
  logic [4:0]           words_done = '0;  // Words moved in this burst
  logic [11:0]          word_idx;

  // Bursts run upward from the line base
  assign word_idx  = bus_addr[13:2] + 12'(words_done);
  assign bus_rdata = mem[word_idx];

  initial
  begin
    for (int i = 0; i < mem_words; i++)
      mem[i] = ~cache_cfg_pkg::word_t'(i);
  end

  //////////////////////////////////////////////////
  // data_ok with 0 to 3 idle cycles per word

  initial
  begin
    int gap;
    gap     = 0;
    data_ok = 1'b0;
    void'($urandom(seed));
    forever
    begin
      @(negedge clk);
      if (!sen || (words_done == 5'(cache_cfg_pkg::line_words)))
      begin
        data_ok = 1'b0;
        gap     = int'($urandom % 4);  // Start delay of the next burst
      end
      else if (gap > 0)
      begin
        data_ok = 1'b0;
        gap     = gap - 1;
      end
      else
      begin
        data_ok = 1'b1;
        gap     = int'($urandom % 4);
      end
    end
  end

  always @(posedge clk)
  begin
    if (!sen)
      words_done <= '0;
    else if (data_ok)
    begin
      if (wen)
        mem[word_idx] = bus_wdata;  // Write-back word
      words_done <= words_done + 1'b1;
    end
  end

endmodule

//--- tb_dcache.sv
module tb_dcache;

  localparam logic [1:0] bus_any    = 2'd0;  // Not checked
  localparam logic [1:0] bus_none   = 2'd1;  // Must hit
  localparam logic [1:0] bus_refill = 2'd2;  // Clean miss
  localparam logic [1:0] bus_evict  = 2'd3;  // Dirty victim goes out first

  localparam int mem_words       = 4096;
  localparam int reset_cycles    = 8;
  localparam int cycles_per_test = 200;

  typedef struct packed {
    logic                 is_write;
    cache_cfg_pkg::addr_t addr;
    cache_cfg_pkg::word_t wdata;
    cache_cfg_pkg::be_t   be;
    logic [1:0]           bus_exp;
    cache_cfg_pkg::addr_t wb_addr;  // Victim line base
  } test_t;

  logic                 clk;
  logic                 rst;
  logic                 req;
  logic                 wreq;
  cache_cfg_pkg::addr_t cpu_addr;
  cache_cfg_pkg::word_t cpu_wdata;
  cache_cfg_pkg::be_t   cpu_be;
  cache_cfg_pkg::word_t cpu_rdata;
  logic                 ok;
  logic                 miss;
  logic                 sen;
  logic                 wen;
  cache_cfg_pkg::addr_t bus_addr;
  cache_cfg_pkg::word_t bus_wdata;
  cache_cfg_pkg::word_t bus_rdata;
  logic                 data_ok;

  test_t                tests [$];
  cache_cfg_pkg::word_t shadow [mem_words];  // Expected memory image
  logic                 table_ready;

  logic                 wb_check;   // Current entry expects a write-back
  cache_cfg_pkg::addr_t wb_expect;  // Its victim line base
  logic [3:0]           wb_word;    // Write-back words moved so far

  dcache_top dcache_top_i
  (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .wreq      (wreq),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_be    (cpu_be),
    .cpu_rdata (cpu_rdata),
    .ok        (ok),
    .miss      (miss),
    .sen       (sen),
    .wen       (wen),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .data_ok   (data_ok)
  );

  tb_bus_memory mem_i
  (
    .clk       (clk),
    .sen       (sen),
    .wen       (wen),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .data_ok   (data_ok)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers

  function automatic cache_cfg_pkg::addr_t line_addr(input int tag, input int index,
                                                     input int word);
    return (cache_cfg_pkg::addr_t'(tag) << 10) | (cache_cfg_pkg::addr_t'(index) << 6) |
           (cache_cfg_pkg::addr_t'(word) << 2);
  endfunction

  function automatic cache_cfg_pkg::addr_t line_base(input cache_cfg_pkg::addr_t addr);
    return {addr[31:6], 6'b0};
  endfunction

  function automatic void add_entry(input logic is_write, input cache_cfg_pkg::addr_t addr,
                                    input cache_cfg_pkg::word_t wdata,
                                    input cache_cfg_pkg::be_t be, input logic [1:0] bus_exp,
                                    input cache_cfg_pkg::addr_t wb_addr);
    test_t t;
    t.is_write = is_write;
    t.addr     = addr;
    t.wdata    = wdata;
    t.be       = be;
    t.bus_exp  = bus_exp;
    t.wb_addr  = wb_addr;
    tests.push_back(t);
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic check_word(input string name, input cache_cfg_pkg::word_t got,
                            input cache_cfg_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("error: %s = %h, expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_addr(input string name, input cache_cfg_pkg::addr_t got,
                            input cache_cfg_pkg::addr_t exp);
    if (got !== exp)
    begin
      $display("error: %s = %h, expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Victim words leave in order from the line base
  always @(posedge clk)
  begin
    if (!sen)
      wb_word <= '0;
    else if (wen && data_ok)
    begin
      if (wb_check)
        check_word("bus_wdata", bus_wdata, shadow[{wb_expect[13:6], wb_word}]);
      wb_word <= wb_word + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus table

  function automatic void build_table();
    // Read miss, then a hit in the same line
    add_entry(1'b0, line_addr(1, 0, 3), 32'h0, 4'h0, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(1, 0, 7), 32'h0, 4'h0, bus_none, 32'h0);
    // Partial byte writes
    add_entry(1'b1, line_addr(1, 1, 2), 32'h1122_3344, 4'b0101, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(1, 1, 2), 32'h0, 4'h0, bus_none, 32'h0);
    add_entry(1'b1, line_addr(1, 1, 2), 32'hAABB_CCDD, 4'b1000, bus_none, 32'h0);
    add_entry(1'b0, line_addr(1, 1, 2), 32'h0, 4'h0, bus_none, 32'h0);
    // Set 5 filled with dirty lines, then evicted oldest first
    add_entry(1'b1, line_addr(1, 5, 0), 32'hD1D1_0001, 4'b1111, bus_refill, 32'h0);
    add_entry(1'b1, line_addr(2, 5, 4), 32'hD2D2_0002, 4'b0011, bus_refill, 32'h0);
    add_entry(1'b1, line_addr(3, 5, 8), 32'hD3D3_0003, 4'b1111, bus_refill, 32'h0);
    add_entry(1'b1, line_addr(4, 5, 15), 32'hD4D4_0004, 4'b1100, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(5, 5, 1), 32'h0, 4'h0, bus_evict, line_addr(1, 5, 0));
    add_entry(1'b0, line_addr(1, 5, 0), 32'h0, 4'h0, bus_evict, line_addr(2, 5, 0));
    add_entry(1'b0, line_addr(2, 5, 4), 32'h0, 4'h0, bus_evict, line_addr(3, 5, 0));
    // Tag 7 is the LRU line of set 2 and gets replaced
    add_entry(1'b0, line_addr(6, 2, 0), 32'h0, 4'h0, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(7, 2, 1), 32'h0, 4'h0, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(8, 2, 2), 32'h0, 4'h0, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(9, 2, 3), 32'h0, 4'h0, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(6, 2, 5), 32'h0, 4'h0, bus_none, 32'h0);
    add_entry(1'b0, line_addr(10, 2, 0), 32'h0, 4'h0, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(6, 2, 9), 32'h0, 4'h0, bus_none, 32'h0);
    add_entry(1'b0, line_addr(7, 2, 1), 32'h0, 4'h0, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(9, 2, 3), 32'h0, 4'h0, bus_none, 32'h0);
    // Mixed traffic
    add_entry(1'b1, line_addr(11, 3, 6), 32'h5A5A_A5A5, 4'b0110, bus_refill, 32'h0);
    add_entry(1'b0, line_addr(11, 3, 6), 32'h0, 4'h0, bus_none, 32'h0);
    add_entry(1'b0, line_addr(1, 0, 15), 32'h0, 4'h0, bus_any, 32'h0);
  endfunction

  task automatic apply_entry(input test_t t);
    logic        saw_burst;
    logic        saw_wb;
    logic        saw_refill;
    logic        saw_miss;
    logic [11:0] widx;
    saw_burst  = 1'b0;
    saw_wb     = 1'b0;
    saw_refill = 1'b0;
    saw_miss   = 1'b0;
    widx       = t.addr[13:2];
    wb_check   = (t.bus_exp == bus_evict);
    wb_expect  = t.wb_addr;
    req        = 1'b1;
    wreq       = t.is_write;
    cpu_addr   = t.addr;
    cpu_wdata  = t.wdata;
    cpu_be     = t.be;
    do
    begin
      @(negedge clk);
      saw_miss = saw_miss | miss;
      if (sen)
      begin
        saw_burst = 1'b1;
        if (wen)
        begin
          saw_wb = 1'b1;
          if (t.bus_exp == bus_evict)
            check_addr("bus_addr", bus_addr, t.wb_addr);
        end
        else
        begin
          saw_refill = 1'b1;
          check_addr("bus_addr", bus_addr, line_base(t.addr));
        end
      end
    end
    while (!ok);

    if (t.is_write)
    begin
      for (int b = 0; b < 4; b++)
        if (t.be[b])
          shadow[widx][8*b +: 8] = t.wdata[8*b +: 8];
    end
    else
      check_word("cpu_rdata", cpu_rdata, shadow[widx]);

    if (((t.bus_exp == bus_refill) || (t.bus_exp == bus_evict)) && !saw_miss)
      report_failure("The miss output never went high on an access that missed");
    case (t.bus_exp)
      bus_none:
        if (saw_burst || saw_miss)
          report_failure("A bus burst or a miss was seen on an access that should hit");
      bus_refill:
        if (!saw_refill || saw_wb)
          report_failure("A clean miss did not refill its line with one read burst");
      bus_evict:
        if (!saw_wb || !saw_refill)
          report_failure("A dirty victim was not written back before the refill");
      default:
        ;
    endcase

    @(negedge clk);  // Inputs held through the ok cycle
    req  = 1'b0;
    wreq = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog

  initial
  begin
    table_ready = 1'b0;
    wb_check    = 1'b0;
    wb_expect   = '0;
    rst         = 1'b1;
    req         = 1'b0;
    wreq        = 1'b0;
    cpu_addr    = '0;
    cpu_wdata   = '0;
    cpu_be      = '0;
    for (int i = 0; i < mem_words; i++)
      shadow[i] = ~cache_cfg_pkg::word_t'(i);
    build_table();
    table_ready = 1'b1;

    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    if (ok || miss || sen || wen)
      report_failure("ok, miss, sen or wen is high while in reset");
    rst = 1'b0;

    foreach (tests[i])
    begin
      @(negedge clk);
      apply_entry(tests[i]);
    end
    $display("Simulation PASSED");
    $finish;
  end

  initial
  begin
    wait (table_ready === 1'b1);
    repeat ((tests.size() + 1) * cycles_per_test) @(posedge clk);
    report_failure("Watchdog timeout, the test table did not finish in time");
  end

endmodule

//--- files.f
cache_cfg_pkg.sv
cache_ctrl_pkg.sv
cache_data_array.sv
data_array_arbiter.sv
cache_tag_store.sv
line_fill_engine.sv
cache_ctrl.sv
dcache_top.sv
tb_bus_memory.sv
tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Simulation PASSED

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
